// ==== Bender.yml ====
package:
  name: raycast_top

export_include_dirs:
  - include

sources:
  - logic/raycast_pkg.sv
  - logic/pixel_scan.sv
  - logic/fp_sqrt.sv
  - logic/sphere_normal.sv
  - logic/shading.sv
  - logic/raycast_top.sv
  - target: test
    files:
      - dv/raycast_checker.sv
      - dv/tb_raycast.sv

// ==== dv/raycast_checker.sv ====
`timescale 1ns/100ps
`include "raycast_consts.svh"

module raycast_checker (
    input logic              clk,
    input logic              rst,
    input logic              credit_ret,
    input logic              ray_valid,
    input logic              ray_ready,
    input raycast_pkg::ray_t ray,
    input logic              busy,
    input logic              pix_valid,
    input logic              pix_last
);
    int used;                              // credits out with rays and pixels not paid back

    always_ff @(posedge clk) begin
        if (!rst) begin
            used <= 0;
        end else begin
            used <= used + int'(ray_valid && ray_ready) - int'(credit_ret);
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (!rst) used <= `RC_CREDITS)
        else $error("more credits in use than the sink granted");

    quiet_in_reset: assert property (@(posedge clk) !rst |=> !pix_valid)
        else $error("pix_valid high during reset");

    ray_hold: assert property (@(posedge clk) disable iff (!rst)
        ray_valid && !ray_ready |=> ray_valid && $stable(ray))
        else $error("ray dropped or changed before ray_ready");

    busy_after_last: assert property (@(posedge clk) disable iff (!rst)
        $fell(busy) |-> $past(pix_valid && pix_last))
        else $error("busy fell without a last pixel");

endmodule

bind raycast_top raycast_checker raycast_checker_i (
    .clk        (clk),
    .rst        (rst),
    .credit_ret (credit_ret),
    .ray_valid  (ray_valid),
    .ray_ready  (ray_ready),
    .ray        (ray),
    .busy       (busy),
    .pix_valid  (pix_valid),
    .pix_last   (pix.tag.last)
);

// ==== dv/tb_raycast.sv ====
`timescale 1ns/100ps
`include "raycast_consts.svh"

module tb_raycast;
    import raycast_pkg::*;

    localparam int NPIX = `RC_WIDTH * `RC_HEIGHT;

    logic        clk;
    logic        rst;
    logic        start;
    logic        credit_ret;
    logic        busy;
    logic        pix_valid;
    pixel_t      pix;
    pixel_t      rx_q[$];                  // pixels seen by the sink in arrival order
    int          owed;                     // credits waiting to go back
    bit          auto_credit;
    logic [31:0] lcg_state;
    int          errors;
    int          failed_tests;

    raycast_top raycast_top_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .credit_ret (credit_ret),
        .busy       (busy),
        .pix_valid  (pix_valid),
        .pix        (pix)
    );

    always #10 clk = ~clk;

    // sink returns one credit per cycle
    always @(negedge clk) begin
        if (pix_valid) begin
            rx_q.push_back(pix);
            owed = owed + int'(auto_credit);
        end
        credit_ret = (owed > 0);
        owed = (owed > 0) ? owed - 1 : 0;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic fp qmul(input fp a, input fp b);
        longint p;
        p = longint'(a) * longint'(b);
        return fp'(p >>> 24);
    endfunction

    // expected color of one pixel from the lighting rules
    function automatic logic [23:0] expect_rgb(input int col, input int row);
        fp      x;
        fp      y;
        fp      z;
        fp      rem;
        fp      dif;
        fp      amb;
        fp      r;
        fp      g;
        fp      b;
        longint rad;
        longint root;
        longint trial;
        x = fp'((2 * col - 7) * (1 << 21));
        y = fp'((2 * row - 7) * (1 << 21));
        rem = `FP_ONE - qmul(x, x) - qmul(y, y);
        if (rem <= 0) begin
            return 24'h0;
        end
        rad = longint'(rem) << 24;
        root = 0;
        for (int k = 24; k >= 0; k--) begin
            trial = root + (longint'(1) << k);
            if (trial * trial <= rad) begin
                root = trial;
            end
        end
        z = fp'(root);
        dif = qmul(x, `LIGHT_X) + qmul(y, `LIGHT_Y) + qmul(z, `LIGHT_Z);
        dif = (dif > 0) ? dif : 0;
        amb = (y > 0) ? y : 0;
        amb = `FP_HALF + qmul(`FP_HALF, amb);   // half-lambert
        r = qmul(amb, `AMB_R) + qmul(dif, `DIFF_R);
        g = qmul(amb, `AMB_G) + qmul(dif, `DIFF_G);
        b = qmul(amb, `AMB_B) + qmul(dif, `DIFF_B);
        return {r[23:16], g[23:16], b[23:16]};
    endfunction

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_pixels(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (rx_q.size() < n && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (rx_q.size() < n) begin
            $display("timeout, only %0d of %0d pixels arrived", rx_q.size(), n);
            errors++;
        end
    endtask

    task automatic wait_idle(input int limit);
        int cycles;
        cycles = 0;
        while (busy !== 1'b0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (busy !== 1'b0) begin
            $display("timeout, busy never dropped after the frame");
            errors++;
        end
    endtask

    task automatic check_frame(input string name);
        logic [6:0]  exp_tag;
        logic [23:0] exp_rgb;
        if (rx_q.size() != NPIX) begin
            $display("ERR %s pixel count expected %0d actual %0d", name, NPIX, rx_q.size());
            errors++;
        end
        for (int i = 0; i < NPIX && i < rx_q.size(); i++) begin
            exp_tag = {3'(i % `RC_WIDTH), 3'(i / `RC_WIDTH), i == NPIX - 1};
            exp_rgb = expect_rgb(i % `RC_WIDTH, i / `RC_WIDTH);
            if (rx_q[i].tag !== exp_tag) begin
                $display("ERR %s pixel %0d tag expected %02h actual %02h",
                         name, i, exp_tag, rx_q[i].tag);
                errors++;
            end
            if (rx_q[i].rgb !== exp_rgb) begin
                $display("ERR %s pixel %0d rgb expected %06h actual %06h",
                         name, i, exp_rgb, rx_q[i].rgb);
                errors++;
            end
        end
    endtask

    task automatic report(input string name, input int e0);
        if (errors != e0) begin
            failed_tests++;
        end
        $display("test %s finished with %0d errors", name, errors - e0);
    endtask

    task automatic run_frame();
        rx_q.delete();
        pulse_start();
        wait_pixels(NPIX, 5000);
        wait_idle(100);
    endtask

    task automatic reset_state_test();
        int e0;
        e0 = errors;
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            if (pix_valid !== 1'b0 || busy !== 1'b0) begin
                $display("ERR reset_state cycle %0d valid/busy expected 0/0 actual %b/%b",
                         i, pix_valid, busy);
                errors++;
            end
        end
        report("reset_state", e0);
    endtask

    task automatic full_frame_test();
        int e0;
        e0 = errors;
        run_frame();
        check_frame("full_frame");
        report("full_frame", e0);
    endtask

    task automatic miss_pixel_test();
        int e0;
        int dx;
        int dy;
        e0 = errors;
        run_frame();
        for (int i = 0; i < NPIX && i < rx_q.size(); i++) begin
            dx = 2 * (i % `RC_WIDTH) - 7;
            dy = 2 * (i / `RC_WIDTH) - 7;
            if (dx * dx + dy * dy >= 64 && rx_q[i].rgb !== 24'h0) begin   // outside the disc
                $display("ERR miss_pixels pixel %0d expected 000000 actual %06h",
                         i, rx_q[i].rgb);
                errors++;
            end
            if (dx * dx + dy * dy < 64 && rx_q[i].rgb === 24'h0) begin
                $display("ERR miss_pixels pixel %0d expected non-black actual 000000", i);
                errors++;
            end
        end
        report("miss_pixels", e0);
    endtask

    task automatic credit_backpressure_test();
        int e0;
        int paid;
        int gap;
        int burst;
        int guard;
        e0 = errors;
        auto_credit = 1'b0;
        rx_q.delete();
        pulse_start();
        wait_pixels(`RC_CREDITS, 1000);
        repeat (200) @(posedge clk);
        if (rx_q.size() != `RC_CREDITS) begin
            $display("ERR credit_backpressure stalled count expected %0d actual %0d",
                     `RC_CREDITS, rx_q.size());
            errors++;
        end
        paid = 0;
        guard = 0;
        while (paid < NPIX && guard < 20000) begin
            gap = lcg_next() % 16;
            repeat (gap + 1) @(posedge clk);
            guard += gap + 1;
            burst = lcg_next() % 4 + 1;
            burst = (burst > rx_q.size() - paid) ? rx_q.size() - paid : burst;
            owed += burst;
            paid += burst;
        end
        if (paid < NPIX) begin
            $display("timeout, frame did not finish while credits were paid back");
            errors++;
        end
        wait_idle(100);
        check_frame("credit_backpressure");
        auto_credit = 1'b1;
        report("credit_backpressure", e0);
    endtask

    task automatic restart_test();
        int e0;
        e0 = errors;
        rx_q.delete();
        pulse_start();
        wait_pixels(8, 1000);
        if (busy !== 1'b1) begin
            $display("busy was low while a frame was still in progress");
            errors++;
        end
        pulse_start();                     // should be ignored
        wait_pixels(NPIX, 5000);
        wait_idle(100);
        repeat (100) @(posedge clk);
        check_frame("restart");
        run_frame();
        check_frame("restart_second");
        report("restart", e0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        start = 1'b0;
        credit_ret = 1'b0;
        owed = 0;
        auto_credit = 1'b1;
        lcg_state = 32'hcd3403ba;
        errors = 0;
        failed_tests = 0;
        repeat (16) @(negedge clk);
        rst = 1'b1;
        reset_state_test();
        full_frame_test();
        miss_pixel_test();
        credit_backpressure_test();
        restart_test();
        $display("tests run 5, tests failed %0d, errors %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== include/raycast_consts.svh ====
`ifndef RAYCAST_CONSTS_SVH
`define RAYCAST_CONSTS_SVH

// frame geometry
`define RC_WIDTH    8
`define RC_HEIGHT   8

`define RC_CREDITS  4                // output credits held by the scanner after reset

// Q8.24 constants
`define FP_ONE      32'sh01000000
`define FP_HALF     32'sh00800000

// light direction, already unit length
`define LIGHT_X     32'sh00000000
`define LIGHT_Y     32'sh0099999a    // 0.6
`define LIGHT_Z     32'sh00cccccd    // 0.8

`define AMB_R       32'sh00333333    // 0.2
`define AMB_G       32'sh004ccccd    // 0.3
`define AMB_B       32'sh00666666    // 0.4

`define DIFF_R      32'sh00cccccd    // 0.8
`define DIFF_G      32'sh00b33333    // 0.7
`define DIFF_B      32'sh00800000    // 0.5

// one result bit per cycle, covers roots up to 2.0
`define SQRT_CYCLES 25

`endif

// ==== logic/fp_sqrt.sv ====
`timescale 1ns/100ps
`include "raycast_consts.svh"

module fp_sqrt (
    input  logic           clk,
    input  logic           rst,
    input  logic           go,
    input  raycast_pkg::fp radicand,
    output logic           done,
    output raycast_pkg::fp root
);
    localparam int N     = `SQRT_CYCLES;
    localparam int FRAC  = 24;
    localparam int CNT_W = $clog2(N + 1);

    logic [2*N-1:0]   opnd;                // radicand times 2^24 shifted out two bits a cycle
    logic [N-1:0]     part;                // partial remainder
    logic [N-1:0]     q;
    logic [CNT_W-1:0] cnt;
    logic [N+1:0]     shifted;
    logic [N+1:0]     trial;

    assign shifted = {part, opnd[2*N-1 -: 2]};
    assign trial   = {q, 2'b01};
    assign root    = {{(32 - N){1'b0}}, q};

    always_ff @(posedge clk) begin
        if (!rst) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                cnt <= CNT_W'(N);
            end else if (cnt != '0) begin
                cnt <= cnt - CNT_W'(1);
                done <= (cnt == CNT_W'(1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            opnd <= {radicand[2*N-FRAC-1:0], {FRAC{1'b0}}};
            part <= '0;
            q    <= '0;
        end else if (cnt != '0) begin
            opnd <= opnd << 2;
            if (shifted >= trial) begin    // restore step not needed
                part <= N'(shifted - trial);
                q    <= {q[N-2:0], 1'b1};
            end else begin
                part <= shifted[N-1:0];
                q    <= {q[N-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== logic/pixel_scan.sv ====
`timescale 1ns/100ps
`include "raycast_consts.svh"

module pixel_scan (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              credit_ret,
    input  logic              ray_ready,
    output logic              ray_valid,
    output raycast_pkg::ray_t ray,
    output logic              busy,
    input  logic              frame_end
);
    import raycast_pkg::*;

    localparam int         CRED_W  = $clog2(`RC_CREDITS + 1);
    localparam logic [2:0] COL_MAX = 3'(`RC_WIDTH - 1);
    localparam logic [2:0] ROW_MAX = 3'(`RC_HEIGHT - 1);

    logic [2:0]        col;
    logic [2:0]        row;
    logic [CRED_W-1:0] credits;
    logic              scan_on;            // rays still to be issued
    logic              take;
    logic              last_pix;

    // pixel centre (2*idx - 7)/8, exact in Q8.24
    function automatic fp grid_coord(input logic [2:0] idx);
        fp v;
        v = fp'({idx, 1'b0}) - fp'(7);
        return v <<< 21;
    endfunction

    assign last_pix  = (col == COL_MAX) && (row == ROW_MAX);
    assign ray_valid = scan_on && (credits != '0);   // stays up until taken
    assign take      = ray_valid && ray_ready;

    assign ray.tag.col  = col;
    assign ray.tag.row  = row;
    assign ray.tag.last = last_pix;
    assign ray.px       = grid_coord(col);
    assign ray.py       = grid_coord(row);

    always_ff @(posedge clk) begin
        if (!rst) begin
            credits <= CRED_W'(`RC_CREDITS);
        end else begin
            credits <= credits - CRED_W'(take) + CRED_W'(credit_ret);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            scan_on <= 1'b0;
            busy    <= 1'b0;
            col     <= '0;
            row     <= '0;
        end else begin
            if (start && !busy) begin
                scan_on <= 1'b1;
                busy    <= 1'b1;
                col     <= '0;
                row     <= '0;
            end else if (take) begin
                if (last_pix) begin
                    scan_on <= 1'b0;
                end
                if (col == COL_MAX) begin
                    col <= '0;
                    row <= row + 3'd1;
                end else begin
                    col <= col + 3'd1;
                end
            end
            if (frame_end) begin
                busy <= 1'b0;                    // last pixel has left the top
            end
        end
    end

endmodule

// ==== logic/raycast_pkg.sv ====
package raycast_pkg;

    typedef logic signed [31:0] fp;    // Q8.24

    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    typedef struct packed {
        logic [2:0] col;
        logic [2:0] row;
        logic       last;              // final pixel of the frame
    } pix_tag_t;

    typedef struct packed {
        pix_tag_t tag;
        fp        px;
        fp        py;
    } ray_t;

    typedef struct packed {
        pix_tag_t tag;
        logic     hit;
        vec3      normal;
    } surf_t;

    typedef struct packed {
        pix_tag_t    tag;
        logic [23:0] rgb;              // r in the top byte
    } pixel_t;

    // Q8.24 product, low fraction bits dropped
    function automatic fp fp_mul(input fp a, input fp b);
        logic signed [63:0] prod;
        prod = a * b;
        return prod[55:24];
    endfunction

    function automatic fp vec3_dot(input vec3 a, input vec3 b);
        fp sum;
        sum = fp_mul(a.x, b.x);
        sum = sum + fp_mul(a.y, b.y);
        sum = sum + fp_mul(a.z, b.z);
        return sum;
    endfunction

endpackage

// ==== logic/raycast_top.sv ====
`timescale 1ns/100ps

module raycast_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                credit_ret,
    output logic                busy,
    output logic                pix_valid,
    output raycast_pkg::pixel_t pix
);
    import raycast_pkg::*;

    logic  ray_valid;
    logic  ray_ready;
    ray_t  ray;
    logic  surf_valid;
    surf_t surf;
    logic  frame_end;

    assign frame_end = pix_valid && pix.tag.last;   // frame done once its last pixel leaves

    pixel_scan pixel_scan_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .credit_ret (credit_ret),
        .ray_ready  (ray_ready),
        .ray_valid  (ray_valid),
        .ray        (ray),
        .busy       (busy),
        .frame_end  (frame_end)
    );

    sphere_normal sphere_normal_i (
        .clk        (clk),
        .rst        (rst),
        .ray_valid  (ray_valid),
        .ray        (ray),
        .ray_ready  (ray_ready),
        .surf_valid (surf_valid),
        .surf       (surf)
    );

    shading shading_i (
        .clk        (clk),
        .rst        (rst),
        .surf_valid (surf_valid),
        .surf       (surf),
        .pix_valid  (pix_valid),
        .pix        (pix)
    );

endmodule

// ==== logic/shading.sv ====
`timescale 1ns/100ps
`include "raycast_consts.svh"

module shading (
    input  logic                clk,
    input  logic                rst,
    input  logic                surf_valid,
    input  raycast_pkg::surf_t  surf,
    output logic                pix_valid,
    output raycast_pkg::pixel_t pix
);
    import raycast_pkg::*;

    localparam vec3 LIGHT = '{x: `LIGHT_X, y: `LIGHT_Y, z: `LIGHT_Z};

    logic     v1;
    logic     hit1;
    pix_tag_t tag1;
    fp        dot_nl;
    fp        amb_comp;                    // normal y, negative part clamped off

    logic     v2;
    pix_tag_t tag2;
    fp        diffuse;
    fp        ambient;

    logic     v3;
    pix_tag_t tag3;
    fp        amb_r;
    fp        amb_g;
    fp        amb_b;
    fp        diff_r;
    fp        diff_g;
    fp        diff_b;

    fp        shade_r;
    fp        shade_g;
    fp        shade_b;

    always_ff @(posedge clk) begin
        if (!rst) begin
            v1        <= 1'b0;
            v2        <= 1'b0;
            v3        <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            v1        <= surf_valid;
            v2        <= v1;
            v3        <= v2;
            pix_valid <= v3;               // misses come out too, as black
        end
    end

    // stage 1: n.l and ambient source
    always_ff @(posedge clk) begin
        tag1     <= surf.tag;
        hit1     <= surf.hit;
        dot_nl   <= surf.hit ? vec3_dot(surf.normal, LIGHT) : '0;
        amb_comp <= (surf.hit && surf.normal.y > fp'(0)) ? surf.normal.y : '0;
    end

    // stage 2: clamp diffuse, half-lambert ambient
    always_ff @(posedge clk) begin
        tag2    <= tag1;
        diffuse <= (dot_nl > fp'(0)) ? dot_nl : '0;
        ambient <= hit1 ? `FP_HALF + fp_mul(`FP_HALF, amb_comp) : '0;
    end

    // stage 3: material colors
    always_ff @(posedge clk) begin
        tag3   <= tag2;
        amb_r  <= fp_mul(ambient, `AMB_R);
        amb_g  <= fp_mul(ambient, `AMB_G);
        amb_b  <= fp_mul(ambient, `AMB_B);
        diff_r <= fp_mul(diffuse, `DIFF_R);
        diff_g <= fp_mul(diffuse, `DIFF_G);
        diff_b <= fp_mul(diffuse, `DIFF_B);
    end

    assign shade_r = amb_r + diff_r;
    assign shade_g = amb_g + diff_g;
    assign shade_b = amb_b + diff_b;

    // stage 4: top fraction byte per channel
    always_ff @(posedge clk) begin
        pix.tag <= tag3;
        pix.rgb <= {shade_r[23:16], shade_g[23:16], shade_b[23:16]};
    end

endmodule

// ==== logic/sphere_normal.sv ====
`timescale 1ns/100ps
`include "raycast_consts.svh"

module sphere_normal (
    input  logic               clk,
    input  logic               rst,
    input  logic               ray_valid,
    input  raycast_pkg::ray_t  ray,
    output logic               ray_ready,
    output logic               surf_valid,
    output raycast_pkg::surf_t surf
);
    import raycast_pkg::*;

    ray_t ray_q;
    logic busy;                            // one ray in flight, held until surf goes out
    logic launch;
    logic take;
    fp    rem;
    logic hit;
    fp    radicand;
    logic sqrt_done;
    fp    sqrt_root;

    assign take      = ray_valid && ray_ready;
    assign ray_ready = !busy;

    // z^2 = 1 - x^2 - y^2 on the unit sphere
    assign rem = `FP_ONE - fp_mul(ray_q.px, ray_q.px) - fp_mul(ray_q.py, ray_q.py);
    assign hit = rem > fp'(0);
    assign radicand = hit ? rem : '0;    // misses still run the root for fixed latency

    fp_sqrt fp_sqrt_i (
        .clk      (clk),
        .rst      (rst),
        .go       (launch),
        .radicand (radicand),
        .done     (sqrt_done),
        .root     (sqrt_root)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy       <= 1'b0;
            launch     <= 1'b0;
            surf_valid <= 1'b0;
        end else begin
            launch     <= take;
            surf_valid <= sqrt_done;
            if (take) begin
                busy <= 1'b1;
            end else if (sqrt_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ray_q <= ray;
        end
        if (sqrt_done) begin
            surf.tag      <= ray_q.tag;
            surf.hit      <= hit;
            surf.normal.x <= hit ? ray_q.px : '0;
            surf.normal.y <= hit ? ray_q.py : '0;
            surf.normal.z <= hit ? sqrt_root : '0;
        end
    end

endmodule

// ==== raycast_top.f ====
+incdir+include
logic/raycast_pkg.sv
logic/pixel_scan.sv
logic/fp_sqrt.sv
logic/sphere_normal.sv
logic/shading.sv
logic/raycast_top.sv
dv/raycast_checker.sv
dv/tb_raycast.sv
